//--- Bender.yml
package:
  name: uart_peripheral

sources:
  - src/uartPkg.sv
  - src/baudTickGen.sv
  - src/uartRec.sv
  - src/uartTrans.sv
  - src/uartFifo.sv
  - src/uartPeripheral.sv
  - target: simulation
    files:
      - sim/uartPeripheral_properties.sv
      - sim/uartPeripheralTb.sv

//--- sim/uartPeripheralTb.sv
/*
 * UART peripheral testbench
 * directed tests for reset state, receive, glitch rejection, transmit
 * order, loopback through both FIFOs and receive overrun
 */
`timescale 1ns/1ns

module uartPeripheralTb;

	localparam int bitClocks   = 64;	// 16 ticks of 4 clocks
	localparam int pollLimit   = 20000;	// status polls before giving up
	localparam int edgeLimit   = 4000;	// clocks to wait for a start bit

	logic clk;
	logic reset;
	uartPkg::uartCmd_t cmd;
	logic [7:0] wrData;
	logic [7:0] rdData;
	logic rxDrive;		// line driven by the tests
	logic loopBack;		// 1: rx follows tx
	logic rxLine;
	logic txLine;
	int unsigned seed;

	assign rxLine = loopBack ? txLine : rxDrive;

	uartPeripheral i_uartPeripheral
	(
		.clk, .reset, .cmd, .wrData, .rdData,
		.rx(rxLine), .tx(txLine)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////
	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected)
			abortRun($sformatf("error: %s is 0x%h, expected 0x%h", name, actual, expected));
	endtask

	// one-cycle command, rdData sampled after the edge that takes it
	task automatic issueCmd(input uartPkg::uartCmd_t c, input logic [7:0] d,
		output logic [7:0] result);
		@(posedge clk);
		cmd    <= c;
		wrData <= d;
		@(posedge clk);
		cmd    <= uartPkg::cmdNone;
		@(negedge clk);
		result = rdData;
	endtask

	// poll status until one bit reaches a level
	// each poll clears the sticky overrun flag
	task automatic waitStatus(input int bitIdx, input logic level, input string what);
		logic [7:0] s;
		int polls;
		polls = 0;
		issueCmd(uartPkg::cmdStatus, 8'h00, s);
		checkValue("overrun flag", s[uartPkg::statOverrun], 1'b0);
		while (s[bitIdx] !== level && polls < pollLimit)
		begin
			issueCmd(uartPkg::cmdStatus, 8'h00, s);
			checkValue("overrun flag", s[uartPkg::statOverrun], 1'b0);
			polls++;
		end
		if (s[bitIdx] !== level)
			abortRun($sformatf("timeout: %s never came", what));
	endtask

	// start, 8 data lsb first, stop; 64 clocks per bit
	task automatic sendFrame(input logic [7:0] data);
		logic [9:0] frame;
		int i;
		frame = {1'b1, data, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			@(posedge clk);
			rxDrive <= frame[i];
			repeat (bitClocks - 1) @(posedge clk);
		end
	endtask

	// decode one frame from tx, sampling at mid-bit
	task automatic recvFrame(output logic [7:0] data);
		logic [7:0] bits;
		int waitCnt;
		int i;
		waitCnt = 0;
		@(negedge clk);
		while (txLine !== 1'b0 && waitCnt < edgeLimit)
		begin
			@(negedge clk);
			waitCnt++;
		end
		if (txLine !== 1'b0)
			abortRun("timeout: no start bit appeared on tx");
		repeat (bitClocks / 2) @(negedge clk);	// middle of start bit
		checkValue("tx start bit", txLine, 1'b0);
		for (i = 0; i < 8; i++)
		begin
			repeat (bitClocks) @(negedge clk);
			bits[i] = txLine;
		end
		repeat (bitClocks) @(negedge clk);
		checkValue("tx stop bit", txLine, 1'b1);
		data = bits;
	endtask

	////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////
	task automatic testResetState;
		logic [7:0] s;
		issueCmd(uartPkg::cmdStatus, 8'h00, s);
		checkValue("status", s, 8'h04);	// tx idle only
		checkValue("tx", txLine, 1'b1);
	endtask

	task automatic testReceiveByte;
		logic [7:0] b, v;
		b = 8'($urandom());
		sendFrame(b);
		waitStatus(uartPkg::statRxAvail, 1'b1, "rx byte available");
		issueCmd(uartPkg::cmdRead, 8'h00, v);
		checkValue("rdData", v, b);
		issueCmd(uartPkg::cmdStatus, 8'h00, v);
		checkValue("status", v, 8'h04);	// rx fifo empty again
	endtask

	task automatic testGlitchReject;
		logic [7:0] b, v;
		@(posedge clk);
		rxDrive <= 1'b0;
		repeat (16) @(posedge clk);	// 4 ticks low
		rxDrive <= 1'b1;
		repeat (10 * bitClocks) @(posedge clk);
		issueCmd(uartPkg::cmdStatus, 8'h00, v);
		checkValue("status after glitch", v, 8'h04);
		b = 8'($urandom());
		sendFrame(b);
		waitStatus(uartPkg::statRxAvail, 1'b1, "rx byte after glitch");
		issueCmd(uartPkg::cmdRead, 8'h00, v);
		checkValue("rdData", v, b);
	endtask

	task automatic testTransmitOrder;
		logic [7:0] sent [3];
		logic [7:0] v;
		int i;
		for (i = 0; i < 3; i++)
		begin
			sent[i] = 8'($urandom());
			issueCmd(uartPkg::cmdWrite, sent[i], v);
		end
		for (i = 0; i < 3; i++)
		begin
			recvFrame(v);
			checkValue("tx byte", v, sent[i]);
		end
		waitStatus(uartPkg::statTxIdle, 1'b1, "tx idle after last frame");
	endtask

	task automatic testLoopBack;
		logic [7:0] sent [16];
		logic [7:0] v;
		int i;
		@(posedge clk);
		loopBack <= 1'b1;
		for (i = 0; i < 16; i++)
		begin
			sent[i] = 8'($urandom());
			issueCmd(uartPkg::cmdWrite, sent[i], v);
		end
		waitStatus(uartPkg::statTxIdle, 1'b1, "tx idle after loopback burst");
		for (i = 0; i < 16; i++)
		begin
			issueCmd(uartPkg::cmdRead, 8'h00, v);
			checkValue("loopback rdData", v, sent[i]);
		end
		issueCmd(uartPkg::cmdStatus, 8'h00, v);
		checkValue("status after loopback", v, 8'h04);	// no overrun
		@(posedge clk);
		loopBack <= 1'b0;
	endtask

	task automatic testOverrun;
		logic [7:0] sent [17];
		logic [7:0] v;
		int i;
		for (i = 0; i < 17; i++)
		begin
			sent[i] = 8'($urandom());
			sendFrame(sent[i]);
		end
		repeat (bitClocks) @(posedge clk);
		issueCmd(uartPkg::cmdStatus, 8'h00, v);
		checkValue("status with overrun", v, 8'h0D);
		issueCmd(uartPkg::cmdStatus, 8'h00, v);
		checkValue("status after clear", v, 8'h05);
		for (i = 0; i < 16; i++)
		begin
			issueCmd(uartPkg::cmdRead, 8'h00, v);
			checkValue("rdData", v, sent[i]);	// 17th byte was lost
		end
		issueCmd(uartPkg::cmdStatus, 8'h00, v);
		checkValue("status drained", v, 8'h04);
	endtask

	////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////
	initial
	begin
		clk      = 1'b0;
		reset    = 1'b1;
		cmd      = uartPkg::cmdNone;
		wrData   = 8'h00;
		rxDrive  = 1'b1;	// idle line
		loopBack = 1'b0;
		seed     = $urandom(39);
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		testResetState();
		testReceiveByte();
		testGlitchReject();
		testTransmitOrder();
		testLoopBack();
		testOverrun();

		$display("Verification passed");
		$finish;
	end

endmodule

//--- sim/uartPeripheral_properties.sv
/*
 * UART receiver and transmitter assertions
 * bound into the peripheral top, watching both state machines
 */
`timescale 1ns/1ns

module uartPeripheralProperties
(
	input logic              clk,
	input logic              reset,
	input logic              sTick,
	input logic              rxDoneTick,
	input uartPkg::rxState_t rxState,
	input uartPkg::txState_t txState,
	input logic              tx
);

	// done pulse only at the last stop tick
	assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> (rxState == uartPkg::rxStStop && sTick))
		else $error("rxDoneTick outside the stop state or without sTick");

	// line idles high
	assert property (@(posedge clk) disable iff (reset)
		(txState == uartPkg::txStIdle) |-> tx)
		else $error("tx low while the transmitter is idle");

	// first cycle out of reset
	assert property (@(posedge clk)
		$fell(reset) |-> (rxState == uartPkg::rxStIdle && txState == uartPkg::txStIdle))
		else $error("state machine not idle after reset");

endmodule

bind uartPeripheral uartPeripheralProperties i_uartPeripheralProperties
(
	.clk, .reset, .sTick, .rxDoneTick,
	.rxState(i_uartRec.stateReg),
	.txState(i_uartTrans.stateReg),
	.tx
);

//--- sources.f
src/uartPkg.sv
src/baudTickGen.sv
src/uartRec.sv
src/uartTrans.sv
src/uartFifo.sv
src/uartPeripheral.sv
sim/uartPeripheral_properties.sv
sim/uartPeripheralTb.sv

//--- src/baudTickGen.sv
/*
 * Oversampling tick generator
 * free-running divider, one-cycle sTick every tickDiv clocks,
 * shared by the receiver and the transmitter
 */
`timescale 1ns/1ns

module baudTickGen
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	uartPkg::divCnt_t divCnt;	// 0 .. tickDiv-1

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
		end
		else if (sTick)
		begin
			divCnt <= '0;	// wrap
		end
		else
		begin
			divCnt <= divCnt + 1'b1;
		end
	end

	// tick on the last count before the wrap
	assign sTick = (divCnt == uartPkg::divCnt_t'(uartPkg::tickDiv - 1));

endmodule

//--- src/uartFifo.sv
/*
 * Synchronous byte FIFO, 16 deep
 * head is read combinationally, pop advances it at the edge;
 * write when full and read when empty are ignored
 */
`timescale 1ns/1ns

module uartFifo
(
	input  logic       clk,
	input  logic       reset,
	input  logic       wr,
	input  logic [7:0] wrData,
	input  logic       rd,
	output logic [7:0] rdData,
	output logic       empty,
	output logic       full
);

	logic [7:0] mem [uartPkg::fifoDepth];
	uartPkg::fifoPtr_t wrPtr, rdPtr;
	uartPkg::fifoCnt_t count;	// occupancy
	logic doWr, doRd;

	assign doWr = wr && !full;
	assign doRd = rd && !empty;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWr)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doRd)
				rdPtr <= rdPtr + 1'b1;
			if (doWr && !doRd)
				count <= count + 1'b1;
			else if (doRd && !doWr)
				count <= count - 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (doWr)
			mem[wrPtr] <= wrData;
	end

	assign rdData = mem[rdPtr];
	assign empty  = (count == '0);
	assign full   = (count == uartPkg::fifoCnt_t'(uartPkg::fifoDepth));

endmodule

//--- src/uartPeripheral.sv
/*
 * UART peripheral top
 * decodes processor commands into FIFO strobes, feeds the transmitter
 * from the tx FIFO, keeps the sticky overrun flag, registers read data
 */
`timescale 1ns/1ns

module uartPeripheral
(
	input  logic              clk,
	input  logic              reset,
	input  uartPkg::uartCmd_t cmd,
	input  logic [7:0]        wrData,
	output logic [7:0]        rdData,
	input  logic              rx,
	output logic              tx
);

	logic sTick;
	logic rxDoneTick;
	logic [7:0] rxByte, rxHead, txHead;
	logic rxEmpty, rxFull, txEmpty, txFull;
	logic txStart, txIdle;
	logic overrun;
	logic [7:0] statusByte;

	////////////////////////////////////////////////////////////////////
	// datapath blocks
	////////////////////////////////////////////////////////////////////
	baudTickGen i_baudTickGen (.clk, .reset, .sTick);

	uartRec i_uartRec (.clk, .reset, .sTick, .rx, .rxDoneTick, .dOut(rxByte));

	uartFifo rxFifo
	(
		.clk, .reset,
		.wr(rxDoneTick), .wrData(rxByte),	// dropped when full
		.rd(cmd == uartPkg::cmdRead), .rdData(rxHead),
		.empty(rxEmpty), .full(rxFull)
	);

	uartFifo txFifo
	(
		.clk, .reset,
		.wr(cmd == uartPkg::cmdWrite), .wrData,
		.rd(txStart), .rdData(txHead),	// pop on the same cycle the byte is latched
		.empty(txEmpty), .full(txFull)
	);

	// kick the transmitter whenever it is free and a byte waits
	assign txStart = txIdle && !txEmpty;

	uartTrans i_uartTrans (.clk, .reset, .sTick, .txStart, .txData(txHead), .tx, .txIdle);

	////////////////////////////////////////////////////////////////////
	// status and read data
	////////////////////////////////////////////////////////////////////
	always_comb
	begin
		statusByte = '0;	// upper bits read as zero
		statusByte[uartPkg::statRxAvail] = !rxEmpty;
		statusByte[uartPkg::statTxFull]  = txFull;
		statusByte[uartPkg::statTxIdle]  = txEmpty && txIdle;
		statusByte[uartPkg::statOverrun] = overrun;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrun <= 1'b0;
			rdData  <= '0;
		end
		else
		begin
			// new loss wins over clear-on-read in the same cycle
			if (rxDoneTick && rxFull)
				overrun <= 1'b1;
			else if (cmd == uartPkg::cmdStatus)
				overrun <= 1'b0;
			case (cmd)
				uartPkg::cmdRead:   rdData <= rxHead;
				uartPkg::cmdStatus: rdData <= statusByte;	// still shows the old flag
				default:            rdData <= rdData;	// hold until next read
			endcase
		end
	end

endmodule

//--- src/uartPkg.sv
/*
 * UART shared definitions
 * frame constants, oversampling divisor, FIFO sizing, status bit
 * positions and the state and command encodings
 */
package uartPkg;

	////////////////////////////////////////////////////////////////////
	// frame format: 8N1, lsb first
	////////////////////////////////////////////////////////////////////
	localparam int dataBits    = 8;		// data bits per frame
	localparam int sbTick      = 16;	// ticks in one stop bit
	localparam int ticksPerBit = 16;	// 16x oversampling
	localparam int midStart    = 7;		// tick count at middle of start bit
	localparam int tickDiv     = 4;		// clocks per oversampling tick, 64 clocks per bit

	// counter widths derived from the above
	localparam int divCntLen  = $clog2(tickDiv);
	localparam int tickCntLen = $clog2(ticksPerBit);
	localparam int bitCntLen  = $clog2(dataBits);

	////////////////////////////////////////////////////////////////////
	// fifo sizing
	////////////////////////////////////////////////////////////////////
	localparam int fifoAddrLen = 4;
	localparam int fifoDepth   = 16;	// 2**fifoAddrLen

	// status byte layout, bits 7..4 read as zero
	localparam int statRxAvail = 0;		// rx fifo not empty
	localparam int statTxFull  = 1;		// tx fifo full
	localparam int statTxIdle  = 2;		// tx fifo empty and transmitter idle
	localparam int statOverrun = 3;		// byte lost since last status read

	typedef logic [divCntLen-1:0]   divCnt_t;
	typedef logic [tickCntLen-1:0]  tickCnt_t;
	typedef logic [bitCntLen-1:0]   bitCnt_t;
	typedef logic [fifoAddrLen-1:0] fifoPtr_t;
	typedef logic [fifoAddrLen:0]   fifoCnt_t;	// one extra bit to tell full from empty

	typedef enum logic [1:0] {rxStIdle, rxStStart, rxStData, rxStStop} rxState_t;
	typedef enum logic [1:0] {txStIdle, txStStart, txStData, txStStop} txState_t;

	// processor side commands, one cycle each
	typedef enum logic [1:0] {cmdNone, cmdRead, cmdWrite, cmdStatus} uartCmd_t;

endpackage

//--- src/uartRec.sv
/*
 * UART receiver, 16x oversampling
 * samples each bit at its middle, lsb first, rejects a start bit
 * that is high again at mid-start, pulses rxDoneTick after the stop bit
 */
`timescale 1ns/1ns

module uartRec
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          sTick,
	input  logic                          rx,
	output logic                          rxDoneTick,
	output logic [uartPkg::dataBits-1:0]  dOut
);

	uartPkg::rxState_t stateReg, stateNext;
	uartPkg::tickCnt_t sReg, sNext;		// oversampling tick count within a bit
	uartPkg::bitCnt_t  nReg, nNext;		// data bit index
	logic [uartPkg::dataBits-1:0] bReg, bNext;	// shift register, fills from the top

	////////////////////////////////////////////////////////////////////
	// state registers
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::rxStIdle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;	// payload only
	end

	////////////////////////////////////////////////////////////////////
	// next state logic
	////////////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			uartPkg::rxStIdle:
				if (!rx)
				begin
					stateNext = uartPkg::rxStStart;	// first low sample
					sNext     = '0;
				end
			uartPkg::rxStStart:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt_t'(uartPkg::midStart))
					begin
						// mid start bit, still low means a real frame
						stateNext = rx ? uartPkg::rxStIdle : uartPkg::rxStData;
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxStData:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt_t'(uartPkg::ticksPerBit - 1))
					begin
						sNext = '0;
						bNext = {rx, bReg[uartPkg::dataBits-1:1]};	// lsb first
						if (nReg == uartPkg::bitCnt_t'(uartPkg::dataBits - 1))
							stateNext = uartPkg::rxStStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxStStop:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt_t'(uartPkg::sbTick - 1))
					begin
						stateNext  = uartPkg::rxStIdle;
						rxDoneTick = 1'b1;	// byte complete
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = uartPkg::rxStIdle;
		endcase
	end

	assign dOut = bReg;

endmodule

//--- src/uartTrans.sv
/*
 * UART transmitter
 * latches a byte on txStart and sends start, 8 data bits lsb first
 * and one stop bit, 16 ticks per bit; line idles high
 */
`timescale 1ns/1ns

module uartTrans
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          sTick,
	input  logic                          txStart,
	input  logic [uartPkg::dataBits-1:0]  txData,
	output logic                          tx,
	output logic                          txIdle
);

	uartPkg::txState_t stateReg, stateNext;
	uartPkg::tickCnt_t sReg, sNext;
	uartPkg::bitCnt_t  nReg, nNext;
	logic [uartPkg::dataBits-1:0] bReg, bNext;	// shifts out from bit 0
	logic txReg, txNext;	// registered line, no glitches on tx

	////////////////////////////////////////////////////////////////////
	// state registers
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::txStIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;	// line idle
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	////////////////////////////////////////////////////////////////////
	// next state logic
	////////////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		txNext    = txReg;
		case (stateReg)
			uartPkg::txStIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					stateNext = uartPkg::txStStart;
					sNext     = '0;
					bNext     = txData;	// latch head byte
					txNext    = 1'b0;	// start bit from next cycle
				end
			end
			uartPkg::txStStart:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt_t'(uartPkg::ticksPerBit - 1))
					begin
						stateNext = uartPkg::txStData;
						sNext     = '0;
						nNext     = '0;
						txNext    = bReg[0];	// first data bit
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::txStData:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt_t'(uartPkg::ticksPerBit - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == uartPkg::bitCnt_t'(uartPkg::dataBits - 1))
						begin
							stateNext = uartPkg::txStStop;
							txNext    = 1'b1;
						end
						else
						begin
							nNext  = nReg + 1'b1;
							txNext = bReg[1];	// next bit
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::txStStop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == uartPkg::tickCnt_t'(uartPkg::sbTick - 1))
						stateNext = uartPkg::txStIdle;	// stop bit done
					else
						sNext = sReg + 1'b1;
				end
			end
			default:
				stateNext = uartPkg::txStIdle;
		endcase
	end

	assign tx     = txReg;
	assign txIdle = (stateReg == uartPkg::txStIdle);

endmodule
